// File: hdl/uncore_config.svh
`ifndef UNCORE_CONFIG_SVH
`define UNCORE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////////////////////////

// Data bus width in bits
`define AHBW 32

//////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////

// Tightly integrated data memory
`define DTIM_BASE 32'h8000_0000
// Depth in 32-bit words, 1 KiB in total
`define DTIM_WORDS 256

// Core-local timer block
`define CLINT_BASE 32'h0200_0000
// Four 32-bit registers
`define CLINT_RANGE 16

`endif

// File: hdl/uncorePkg.sv
`include "uncore_config.svh"

package uncorePkg;

  //////////////////////////////////////////////////////////////////////
  // Bus vectors
  //////////////////////////////////////////////////////////////////////

  // One beat of read or write data
  typedef logic [`AHBW-1:0] busData_t;

  // Byte address on the bus
  typedef logic [31:0] busAddr_t;

  // Full 64-bit machine timer value
  typedef logic [63:0] mtime_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // HSIZE values that the slaves understand
  typedef enum logic [2:0] {
    sizeByte = 3'b000,
    sizeHalf = 3'b001,
    sizeWord = 3'b010
  } hsize_t;

  // CLINT word offsets, taken from address bits 3:2
  typedef enum logic [1:0] {
    regCmpLo  = 2'd0,
    regCmpHi  = 2'd1,
    regTimeLo = 2'd2,
    regTimeHi = 2'd3
  } clintReg_t;

endpackage

// File: hdl/ahbSlaveIf.sv
`timescale 1ns/100ps

// Data-phase view of the bus as seen by one slave
interface ahbSlaveIf;

  // Select for this slave, high for one data-phase cycle
  logic                 selD;
  // Address and controls captured at the end of the address phase
  uncorePkg::busAddr_t  addrD;
  uncorePkg::hsize_t    sizeD;
  logic                 writeD;
  // Write data straight from the master
  uncorePkg::busData_t  wdata;
  // Read data back toward the multiplexer
  uncorePkg::busData_t  rdata;

  // Interconnect side
  modport ic (
    output selD,
    output addrD,
    output sizeD,
    output writeD,
    output wdata,
    input  rdata
  );

  // Slave side
  modport slave (
    input  selD,
    input  addrD,
    input  sizeD,
    input  writeD,
    input  wdata,
    output rdata
  );

endinterface

// File: hdl/ahbInterconnect.sv
`timescale 1ns/100ps
`include "uncore_config.svh"

module ahbInterconnect (
  input  logic                HCLK,
  input  logic                rst,
  input  uncorePkg::busAddr_t HADDR,
  input  logic [1:0]          HTRANS,
  input  logic                HWRITE,
  input  uncorePkg::hsize_t   HSIZE,
  input  uncorePkg::busData_t HWDATA,
  output uncorePkg::busData_t HRDATA,
  ahbSlaveIf.ic               dtimBus,
  ahbSlaveIf.ic               clintBus
);

  // Address-phase hits
  logic                dtimHit;
  logic                clintHit;
  // Data-phase copies
  logic                dtimSelD;
  logic                clintSelD;
  uncorePkg::busAddr_t addrD;
  uncorePkg::hsize_t   sizeD;
  logic                writeD;

  // True when addr lies in [base, base + range)
  function automatic logic inRange(uncorePkg::busAddr_t addr,
                                   uncorePkg::busAddr_t base,
                                   uncorePkg::busAddr_t range);
    return (addr >= base) && (addr < base + range);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  // Only NONSEQ and SEQ beats count, so HTRANS bit 1 qualifies the hit
  assign dtimHit  = HTRANS[1] && inRange(HADDR, `DTIM_BASE, `DTIM_WORDS * 4);
  assign clintHit = HTRANS[1] && inRange(HADDR, `CLINT_BASE, `CLINT_RANGE);

  //////////////////////////////////////////////////////////////////////
  // Address to data phase
  //////////////////////////////////////////////////////////////////////

  // Selects are control state
  always_ff @(posedge HCLK) begin
    if (rst) begin
      dtimSelD  <= 1'b0;
      clintSelD <= 1'b0;
    end else begin
      dtimSelD  <= dtimHit;
      clintSelD <= clintHit;
    end
  end

  // Shared controls ride along, qualified later by the selects
  always_ff @(posedge HCLK) begin
    addrD  <= HADDR;
    sizeD  <= HSIZE;
    writeD <= HWRITE;
  end

  // Fan the data phase out to both slaves
  assign dtimBus.selD    = dtimSelD;
  assign dtimBus.addrD   = addrD;
  assign dtimBus.sizeD   = sizeD;
  assign dtimBus.writeD  = writeD;
  assign dtimBus.wdata   = HWDATA;
  assign clintBus.selD   = clintSelD;
  assign clintBus.addrD  = addrD;
  assign clintBus.sizeD  = sizeD;
  assign clintBus.writeD = writeD;
  assign clintBus.wdata  = HWDATA;

  // Read mux; an unmapped beat has no select and reads zero
  assign HRDATA = ({`AHBW{dtimSelD}}  & dtimBus.rdata) |
                  ({`AHBW{clintSelD}} & clintBus.rdata);

endmodule

// File: hdl/dtim.sv
`timescale 1ns/100ps
`include "uncore_config.svh"

module dtim (
  input  logic    HCLK,
  input  logic    rst,
  ahbSlaveIf.slave bus
);

  // Word index width
  localparam int IdxW = $clog2(`DTIM_WORDS);

  // Storage, one 32-bit word per entry
  uncorePkg::busData_t mem [`DTIM_WORDS];

  logic [IdxW-1:0] wordIdx;
  logic [3:0]      laneEn;
  logic            wrEn;

  //////////////////////////////////////////////////////////////////////
  // Data-phase decode
  //////////////////////////////////////////////////////////////////////

  // Byte offset bits are dropped
  assign wordIdx = bus.addrD[IdxW+1:2];

  // Write only on a selected write beat
  assign wrEn = bus.selD && bus.writeD;

  // Byte-lane enables from size and low address bits
  always_comb begin
    case (bus.sizeD)
      uncorePkg::sizeByte: laneEn = 4'b0001 << bus.addrD[1:0];
      // Halfword picks the lower or upper pair
      uncorePkg::sizeHalf: laneEn = bus.addrD[1] ? 4'b1100 : 4'b0011;
      uncorePkg::sizeWord: laneEn = 4'b1111;
      // Larger sizes are not supported on a 32-bit bus
      default:             laneEn = 4'b0000;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Memory array
  //////////////////////////////////////////////////////////////////////

  // Write lands at the edge that closes the data phase
  always_ff @(posedge HCLK) begin
    if (rst) begin
      // Contents come up as zero
      for (int i = 0; i < `DTIM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wrEn) begin
      for (int b = 0; b < 4; b++) begin
        // Unwritten lanes hold their old byte
        if (laneEn[b]) begin
          mem[wordIdx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read is combinational in the data phase
  // The interconnect masks it when this slave is not selected
  assign bus.rdata = mem[wordIdx];

endmodule

// File: hdl/clint.sv
`timescale 1ns/100ps

module clint (
  input  logic              HCLK,
  input  logic              rst,
  ahbSlaveIf.slave          bus,
  output logic              TimerInt,
  output uncorePkg::mtime_t mtime
);

  // Compare value for the timer interrupt
  uncorePkg::mtime_t   mtimecmp;

  // Register select from the data-phase address
  uncorePkg::clintReg_t offset;
  logic                 wrEn;

  //////////////////////////////////////////////////////////////////////
  // Register access decode
  //////////////////////////////////////////////////////////////////////

  // Word offset within the 16-byte window
  assign offset = uncorePkg::clintReg_t'(bus.addrD[3:2]);

  // Whole-word writes only, size is ignored
  assign wrEn = bus.selD && bus.writeD;

  //////////////////////////////////////////////////////////////////////
  // Timer registers
  //////////////////////////////////////////////////////////////////////

  // Free-running counter
  // A write replaces one half and suppresses the increment for that edge
  always_ff @(posedge HCLK) begin
    if (rst) begin
      mtime <= '0;
    end else if (wrEn && offset == uncorePkg::regTimeLo) begin
      mtime <= {mtime[63:32], bus.wdata};
    end else if (wrEn && offset == uncorePkg::regTimeHi) begin
      mtime <= {bus.wdata, mtime[31:0]};
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // Compare register starts at all ones so no interrupt fires
  always_ff @(posedge HCLK) begin
    if (rst) begin
      mtimecmp <= '1;
    end else if (wrEn && offset == uncorePkg::regCmpLo) begin
      mtimecmp <= {mtimecmp[63:32], bus.wdata};
    end else if (wrEn && offset == uncorePkg::regCmpHi) begin
      mtimecmp <= {bus.wdata, mtimecmp[31:0]};
    end
  end

  // Interrupt flop
  // Compares the values held before the edge
  always_ff @(posedge HCLK) begin
    if (rst) begin
      TimerInt <= 1'b0;
    end else begin
      TimerInt <= (mtime >= mtimecmp);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read-back
  //////////////////////////////////////////////////////////////////////

  // Addressed word, live in the data phase
  always_comb begin
    case (offset)
      uncorePkg::regCmpLo:  bus.rdata = mtimecmp[31:0];
      uncorePkg::regCmpHi:  bus.rdata = mtimecmp[63:32];
      uncorePkg::regTimeLo: bus.rdata = mtime[31:0];
      uncorePkg::regTimeHi: bus.rdata = mtime[63:32];
      default:              bus.rdata = '0;
    endcase
  end

endmodule

// File: hdl/uncore.sv
`timescale 1ns/100ps

module uncore (
  // AHB-Lite slave side
  input  logic                HCLK,
  input  logic                rst,
  input  uncorePkg::busAddr_t HADDR,
  input  logic [1:0]          HTRANS,
  input  logic                HWRITE,
  input  uncorePkg::hsize_t   HSIZE,
  input  uncorePkg::busData_t HWDATA,
  output uncorePkg::busData_t HRDATA,
  // Timer outputs toward the hart
  output logic                TimerInt,
  output uncorePkg::mtime_t   mtime
);

  //////////////////////////////////////////////////////////////////////
  // Data-phase buses
  //////////////////////////////////////////////////////////////////////

  // One bus per slave
  ahbSlaveIf dtimBus ();
  ahbSlaveIf clintBus ();

  //////////////////////////////////////////////////////////////////////
  // Decode, phase register and read mux
  //////////////////////////////////////////////////////////////////////

  ahbInterconnect icUnit (
    .HCLK     (HCLK),
    .rst      (rst),
    .HADDR    (HADDR),
    .HTRANS   (HTRANS),
    .HWRITE   (HWRITE),
    .HSIZE    (HSIZE),
    .HWDATA   (HWDATA),
    .HRDATA   (HRDATA),
    .dtimBus  (dtimBus),
    .clintBus (clintBus)
  );

  //////////////////////////////////////////////////////////////////////
  // Slaves
  //////////////////////////////////////////////////////////////////////

  // Tightly integrated data memory
  dtim dtimUnit (
    .HCLK (HCLK),
    .rst  (rst),
    .bus  (dtimBus)
  );

  // Core-local timer
  clint clintUnit (
    .HCLK     (HCLK),
    .rst      (rst),
    .bus      (clintBus),
    .TimerInt (TimerInt),
    .mtime    (mtime)
  );

endmodule

// File: dv/uncore_assert.sv
`timescale 1ns/100ps

// Timer interrupt checks, bound into the uncore top level
module uncore_assert (
  input logic                HCLK,
  input logic                rst,
  input logic                TimerInt,
  input uncorePkg::mtime_t   mtime,
  input uncorePkg::mtime_t   mtimecmp,
  input logic                cmpWr
);

  // Failure tallies, one per property, summed by the testbench
  int earlyIntFails = 0;
  int intRuleFails  = 0;

  // Goes high at the edge where the first compare write lands
  logic cmpSeen;

  always_ff @(posedge HCLK) begin
    if (rst) begin
      cmpSeen <= 1'b0;
    end else if (cmpWr) begin
      cmpSeen <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Timer interrupt
  //////////////////////////////////////////////////////////////////////

  // Reset compare value is all ones, so nothing fires before a write
  noEarlyInt: assert property (@(posedge HCLK) disable iff (rst) !cmpSeen |-> !TimerInt)
    else begin
      $error("TimerInt set before any mtimecmp write");
      earlyIntFails++;
    end

  // Flop output follows the compare of the previous cycle
  intRule: assert property (@(posedge HCLK) disable iff (rst)
      !$past(rst) |-> (TimerInt == ($past(mtime) >= $past(mtimecmp))))
    else begin
      $error("TimerInt does not match mtime >= mtimecmp of the previous cycle");
      intRuleFails++;
    end

endmodule

bind uncore uncore_assert assertUnit (
  .HCLK     (HCLK),
  .rst      (rst),
  .TimerInt (TimerInt),
  .mtime    (mtime),
  .mtimecmp (clintUnit.mtimecmp),
  .cmpWr    (clintBus.selD && clintBus.writeD && !clintBus.addrD[3])
);

// File: dv/uncoreTb.sv
`timescale 1ns/100ps
`include "uncore_config.svh"

module uncoreTb;

  // Far above the few hundred cycles the sequence takes
  localparam int TimeoutCycles = 4000;
  // CLINT register addresses
  localparam uncorePkg::busAddr_t CmpLo  = `CLINT_BASE;
  localparam uncorePkg::busAddr_t CmpHi  = `CLINT_BASE + 32'd4;
  localparam uncorePkg::busAddr_t TimeLo = `CLINT_BASE + 32'd8;
  localparam uncorePkg::busAddr_t TimeHi = `CLINT_BASE + 32'd12;

  logic                HCLK;
  logic                rst;
  uncorePkg::busAddr_t HADDR;
  logic [1:0]          HTRANS;
  logic                HWRITE;
  uncorePkg::hsize_t   HSIZE;
  uncorePkg::busData_t HWDATA;
  uncorePkg::busData_t HRDATA;
  logic                TimerInt;
  uncorePkg::mtime_t   mtime;

  // Reference state
  logic [7:0]          dtimModel [`DTIM_WORDS*4];
  uncorePkg::mtime_t   cmpModel;
  uncorePkg::mtime_t   timeBase;
  int                  timeCycle;
  logic [31:0]         rng;
  int                  cycle = 0;
  // Beat currently in its data phase
  uncorePkg::busData_t pendWdata;
  logic                pendRead;
  logic                pendCheck;
  uncorePkg::busData_t pendExp;
  string               pendName;
  uncorePkg::busData_t lastRead;

  uncore u_dut (
    .HCLK(HCLK), .rst(rst), .HADDR(HADDR), .HTRANS(HTRANS), .HWRITE(HWRITE),
    .HSIZE(HSIZE), .HWDATA(HWDATA), .HRDATA(HRDATA), .TimerInt(TimerInt), .mtime(mtime)
  );

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling
  //////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic checkValue(input string name, input uncorePkg::busData_t exp,
                            input uncorePkg::busData_t act);
    assert (act === exp) else begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      abortRun();
    end
  endtask

  // Failures counted by the bound assertion module
  function automatic int assertFails();
    return u_dut.assertUnit.earlyIntFails + u_dut.assertUnit.intRuleFails;
  endfunction

  always @(posedge HCLK) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      abortRun();
    end
  end

  always @(negedge HCLK) begin
    if (assertFails() != 0) begin
      $display("A bound assertion on the timer interrupt failed");
      abortRun();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic uncorePkg::busData_t modelWord(input uncorePkg::busAddr_t addr);
    uncorePkg::busAddr_t off;
    int word;
    off = addr - `DTIM_BASE;
    word = int'({off[31:2], 2'b00});
    return {dtimModel[word+3], dtimModel[word+2], dtimModel[word+1], dtimModel[word]};
  endfunction

  // Lanes follow the size and the low address bits, aligned to the size
  function automatic void modelWrite(input uncorePkg::busAddr_t addr,
                                     input uncorePkg::hsize_t size,
                                     input uncorePkg::busData_t data);
    uncorePkg::busAddr_t off;
    int word;
    int count;
    int first;
    off = addr - `DTIM_BASE;
    word = int'({off[31:2], 2'b00});
    case (size)
      uncorePkg::sizeByte: count = 1;
      uncorePkg::sizeHalf: count = 2;
      default:             count = 4;
    endcase
    first = int'(off[1:0]) & ~(count - 1);
    for (int b = first; b < first + count; b++) begin
      dtimModel[word+b] = data[8*b +: 8];
    end
  endfunction

  // mtime right after edge number c, counted from the last mtime write
  function automatic uncorePkg::mtime_t timeAt(input int c);
    return timeBase + uncorePkg::mtime_t'(c - timeCycle);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus driver
  //////////////////////////////////////////////////////////////////////

  // New address phase plus write data of the beat before, checked mid-cycle
  task automatic issue(input logic valid, input uncorePkg::busAddr_t addr,
                       input logic write, input uncorePkg::hsize_t size,
                       input uncorePkg::busData_t wdata, input logic check,
                       input uncorePkg::busData_t exp, input string name);
    @(posedge HCLK);
    HADDR  <= addr;
    HTRANS <= valid ? 2'b10 : 2'b00;
    HWRITE <= write;
    HSIZE  <= size;
    HWDATA <= pendWdata;
    @(negedge HCLK);
    if (pendRead) begin
      lastRead = HRDATA;
    end
    if (pendCheck) begin
      checkValue(pendName, pendExp, HRDATA);
    end
    pendWdata = wdata;
    pendRead  = valid && !write;
    pendCheck = valid && !write && check;
    pendExp   = exp;
    pendName  = name;
  endtask

  task automatic idle();
    issue(1'b0, '0, 1'b0, uncorePkg::sizeWord, '0, 1'b0, '0, "idle");
  endtask

  task automatic writeBeat(input uncorePkg::busAddr_t addr, input uncorePkg::hsize_t size,
                           input uncorePkg::busData_t data);
    issue(1'b1, addr, 1'b1, size, data, 1'b0, '0, "write");
  endtask

  task automatic readBeat(input uncorePkg::busAddr_t addr, input uncorePkg::busData_t exp,
                          input string name);
    issue(1'b1, addr, 1'b0, uncorePkg::sizeWord, '0, 1'b1, exp, name);
  endtask

  task automatic dtimWrite(input uncorePkg::busAddr_t addr, input uncorePkg::hsize_t size,
                           input uncorePkg::busData_t data);
    modelWrite(addr, size, data);
    writeBeat(addr, size, data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    uncorePkg::busAddr_t addrs [40];
    uncorePkg::busAddr_t a;
    uncorePkg::mtime_t   target;
    uncorePkg::mtime_t   expTime;
    uncorePkg::busData_t expInt;
    rst = 1'b1;
    HADDR = '0;
    HTRANS = 2'b00;
    HWRITE = 1'b0;
    HSIZE = uncorePkg::sizeWord;
    HWDATA = '0;
    rng = 32'd87;
    pendWdata = '0;
    pendRead = 1'b0;
    pendCheck = 1'b0;
    pendExp = '0;
    pendName = "";
    lastRead = '0;
    cmpModel = '1;
    for (int i = 0; i < `DTIM_WORDS * 4; i++) begin
      dtimModel[i] = '0;
    end
    repeat (16) @(posedge HCLK);
    rst <= 1'b0;

    // Random word writes, then all read back with overlapping phases
    for (int i = 0; i < 40; i++) begin
      rng = xorshift(rng);
      addrs[i] = `DTIM_BASE + (rng & 32'h0000_03FC);
      rng = xorshift(rng);
      dtimWrite(addrs[i], uncorePkg::sizeWord, rng);
    end
    for (int i = 0; i < 40; i++) begin
      readBeat(addrs[i], modelWord(addrs[i]), "word access");
    end

    // Every byte lane, then both halfword lanes
    rng = xorshift(rng);
    a = `DTIM_BASE + (rng & 32'h0000_03FC);
    for (int off = 0; off < 4; off++) begin
      rng = xorshift(rng);
      dtimWrite(a + off, uncorePkg::sizeByte, rng);
      readBeat(a, modelWord(a), "byte write");
    end
    for (int off = 0; off < 4; off += 2) begin
      rng = xorshift(rng);
      dtimWrite(a + off, uncorePkg::sizeHalf, rng);
      readBeat(a, modelWord(a), "halfword write");
    end

    // Read in the address phase right after the write
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      a = `DTIM_BASE + (rng & 32'h0000_03FC);
      rng = xorshift(rng);
      dtimWrite(a, uncorePkg::sizeWord, rng);
      readBeat(a, modelWord(a), "read after write");
    end

    // Address phases five cycles apart
    issue(1'b1, TimeLo, 1'b0, uncorePkg::sizeWord, '0, 1'b0, '0, "mtime first read");
    repeat (4) idle();
    readBeat(TimeLo, lastRead + 32'd5, "mtime count");
    rng = xorshift(rng);
    timeBase = {32'd0, rng & 32'h0FFF_FFFF};
    writeBeat(TimeHi, uncorePkg::sizeWord, '0);
    writeBeat(TimeLo, uncorePkg::sizeWord, timeBase[31:0]);
    readBeat(TimeLo, timeBase[31:0], "mtime write");
    idle();
    // Now inside that read's data phase
    timeCycle = cycle;

    // Compare 20 counts ahead, interrupt sampled across the crossing
    writeBeat(CmpHi, uncorePkg::sizeWord, '0);
    idle();
    target = timeAt(cycle) + 64'd20;
    cmpModel = target;
    writeBeat(CmpLo, uncorePkg::sizeWord, target[31:0]);
    repeat (2) idle();
    for (int i = 0; i < 30; i++) begin
      idle();
      expInt = (timeAt(cycle - 1) >= cmpModel) ? 32'd1 : 32'd0;
      checkValue("timer interrupt", expInt, {31'd0, TimerInt});
      // Counter port keeps pace with the edges since the write
      expTime = timeAt(cycle);
      checkValue("mtime port low", expTime[31:0], mtime[31:0]);
      checkValue("mtime port high", expTime[63:32], mtime[63:32]);
    end
    cmpModel = '1;
    writeBeat(CmpLo, uncorePkg::sizeWord, '1);
    writeBeat(CmpHi, uncorePkg::sizeWord, '1);
    repeat (3) idle();
    checkValue("timer clear", '0, {31'd0, TimerInt});

    // Holes in the map, including just past each range
    readBeat(32'h1000_0000, '0, "unmapped read");
    readBeat(`DTIM_BASE + 32'd1024, '0, "unmapped read");
    readBeat(`CLINT_BASE + 32'd16, '0, "unmapped read");
    rng = xorshift(rng);
    writeBeat(`DTIM_BASE + 32'd1024 + (addrs[0] & 32'h0000_03FC), uncorePkg::sizeWord, rng);
    writeBeat(`CLINT_BASE + 32'd16, uncorePkg::sizeWord, rng);
    readBeat(addrs[0], modelWord(addrs[0]), "unmapped write");
    readBeat(CmpLo, cmpModel[31:0], "unmapped write");
    readBeat(CmpHi, cmpModel[63:32], "unmapped write");
    idle();

    if (assertFails() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("A bound assertion failed during the run");
      abortRun();
    end
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/uncorePkg.sv
hdl/ahbSlaveIf.sv
hdl/ahbInterconnect.sv
hdl/dtim.sv
hdl/clint.sv
hdl/uncore.sv
dv/uncore_assert.sv
dv/uncoreTb.sv

// File: Makefile
TOP := uncoreTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f hdl/*.sv hdl/*.svh dv/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
